// File: source/aes_pkg.sv
`default_nettype none

package aes_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [3:0]   round_t;

    // last round key index.
    localparam round_t NUM_ROUNDS = 4'd10;
    localparam byte_t  RCON_INIT  = 8'h01;
    localparam byte_t  GF_POLY    = 8'h1b;

    typedef enum logic [1:0] {
        KEY_IDLE,
        KEY_EXPAND,
        KEY_READY
    } key_state_t;

    typedef enum logic {
        DEC_IDLE,
        DEC_RUN
    } dec_state_t;

    // multiply by x in GF(2^8).
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? GF_POLY : 8'h00);
    endfunction

endpackage

`default_nettype wire

// File: source/aes_sbox.sv
`timescale 1ns/1ns
`default_nettype none

module aes_sbox
    import aes_pkg::*;
(
    input  wire byte_t in_byte,
    output byte_t      out_byte
);

    logic [127:0] row;

    // same row layout as the inverse table.
    always_comb begin
        case (in_byte[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
        endcase
    end

    assign out_byte = row[8 * (4'd15 - in_byte[3:0]) +: 8];

endmodule

`default_nettype wire

// File: source/aes_inv_sbox.sv
`timescale 1ns/1ns
`default_nettype none

module aes_inv_sbox
    import aes_pkg::*;
(
    input  wire byte_t in_byte,
    output byte_t      out_byte
);

    logic [127:0] row;

    // high nibble picks a row of sixteen entries.
    always_comb begin
        case (in_byte[7:4])
            4'h0: row = 128'h52096ad53036a538bf40a39e81f3d7fb;
            4'h1: row = 128'h7ce339829b2fff87348e4344c4dee9cb;
            4'h2: row = 128'h547b9432a6c2233dee4c950b42fac34e;
            4'h3: row = 128'h082ea16628d924b2765ba2496d8bd125;
            4'h4: row = 128'h72f8f66486689816d4a45ccc5d65b692;
            4'h5: row = 128'h6c704850fdedb9da5e154657a78d9d84;
            4'h6: row = 128'h90d8ab008cbcd30af7e45805b8b34506;
            4'h7: row = 128'hd02c1e8fca3f0f02c1afbd0301138a6b;
            4'h8: row = 128'h3a9111414f67dcea97f2cfcef0b4e673;
            4'h9: row = 128'h96ac7422e7ad3585e2f937e81c75df6e;
            4'ha: row = 128'h47f11a711d29c5896fb7620eaa18be1b;
            4'hb: row = 128'hfc563e4bc6d279209adbc0fe78cd5af4;
            4'hc: row = 128'h1fdda8338807c731b11210592780ec5f;
            4'hd: row = 128'h60517fa919b54a0d2de57a9f93c99cef;
            4'he: row = 128'ha0e03b4dae2af5b0c8ebbb3c83539961;
            default: row = 128'h172b047eba77d626e169146355210c7d;
        endcase
    end

    // entry 0 of a row is its top byte.
    assign out_byte = row[8 * (4'd15 - in_byte[3:0]) +: 8];

endmodule

`default_nettype wire

// File: source/aes_key_expand.sv
`timescale 1ns/1ns
`default_nettype none

module aes_key_expand
    import aes_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         load,
    input  wire block_t key,
    input  wire round_t round_sel,
    output block_t      round_key,
    output logic        ready
);

    key_state_t state;
    round_t     rk_idx;
    byte_t      rcon;
    block_t     rk_mem [0:NUM_ROUNDS];
    block_t     prev_key;
    block_t     next_key;
    word_t      rot_word;
    word_t      temp_word;
    wire word_t sub_word;

    // newest stored key feeds the next step.
    assign prev_key = rk_mem[rk_idx];
    assign rot_word = {prev_key[23:0], prev_key[31:24]};

    for (genvar i = 0; i < 4; i++) begin : g_sub
        aes_sbox u_sbox (
            .in_byte (rot_word[31 - 8 * i -: 8]),
            .out_byte(sub_word[31 - 8 * i -: 8])
        );
    end

    assign temp_word = sub_word ^ {rcon, 24'h000000};

    // each word chains off the one before it.
    assign next_key[127:96] = prev_key[127:96] ^ temp_word;
    assign next_key[95:64]  = prev_key[95:64] ^ next_key[127:96];
    assign next_key[63:32]  = prev_key[63:32] ^ next_key[95:64];
    assign next_key[31:0]   = prev_key[31:0] ^ next_key[63:32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= KEY_IDLE;
            rk_idx <= '0;
            rcon   <= RCON_INIT;
        end else if (load) begin
            state  <= KEY_EXPAND;
            rk_idx <= '0;
            rcon   <= RCON_INIT;
        end else if (state == KEY_EXPAND) begin
            rk_idx <= rk_idx + 4'd1;
            rcon   <= xtime(rcon);
            if (rk_idx == NUM_ROUNDS - 4'd1) begin
                state <= KEY_READY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rk_mem[0] <= key;
        end else if (state == KEY_EXPAND) begin
            rk_mem[rk_idx + 4'd1] <= next_key;
        end
    end

    assign round_key = rk_mem[round_sel];
    assign ready     = (state == KEY_READY);

endmodule

`default_nettype wire

// File: source/aes_inv_round.sv
`timescale 1ns/1ns
`default_nettype none

module aes_inv_round
    import aes_pkg::*;
(
    input  wire block_t cur_state,
    input  wire block_t round_key,
    input  wire         last,
    output block_t      next_state
);

    byte_t       shifted [16];
    wire byte_t  sub_b [16];
    wire block_t added;
    wire block_t mixed;

    // one column of InvMixColumns.
    function automatic word_t inv_mix_col(word_t col);
        byte_t a [4];
        byte_t m9 [4];
        byte_t m11 [4];
        byte_t m13 [4];
        byte_t m14 [4];
        byte_t x2;
        byte_t x4;
        byte_t x8;
        for (int k = 0; k < 4; k++) begin
            a[k]   = col[31 - 8 * k -: 8];
            x2     = xtime(a[k]);
            x4     = xtime(x2);
            x8     = xtime(x4);
            m9[k]  = x8 ^ a[k];
            m11[k] = x8 ^ x2 ^ a[k];
            m13[k] = x8 ^ x4 ^ a[k];
            m14[k] = x8 ^ x4 ^ x2;
        end
        return {m14[0] ^ m11[1] ^ m13[2] ^ m9[3],
                m9[0] ^ m14[1] ^ m11[2] ^ m13[3],
                m13[0] ^ m9[1] ^ m14[2] ^ m11[3],
                m11[0] ^ m13[1] ^ m9[2] ^ m14[3]};
    endfunction

    for (genvar i = 0; i < 16; i++) begin : g_byte
        // row r moves right by r columns.
        assign shifted[i] = cur_state[127 - 8 * (4 * ((i / 4 + 4 - i % 4) % 4) + i % 4) -: 8];

        aes_inv_sbox u_inv_sbox (
            .in_byte (shifted[i]),
            .out_byte(sub_b[i])
        );

        assign added[127 - 8 * i -: 8] = sub_b[i] ^ round_key[127 - 8 * i -: 8];
    end

    for (genvar c = 0; c < 4; c++) begin : g_col
        assign mixed[127 - 32 * c -: 32] = inv_mix_col(added[127 - 32 * c -: 32]);
    end

    // final round skips the column mix.
    assign next_state = last ? added : mixed;

endmodule

`default_nettype wire

// File: source/aes_decrypt.sv
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt
    import aes_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         key_load,
    input  wire block_t key,
    input  wire         start,
    input  wire block_t ciphertext,
    output logic        key_ready,
    output logic        busy,
    output logic        done,
    output block_t      plaintext
);

    dec_state_t state;
    round_t     round_cnt;
    round_t     round_sel;
    block_t     round_key;
    block_t     round_state;
    block_t     next_state;
    logic       load;
    logic       last;
    logic       accept;

    // keys stay frozen for the whole block.
    assign load   = key_load & ~busy;
    assign busy   = (state == DEC_RUN);
    assign accept = start & key_ready & (state == DEC_IDLE);

    // idle points at key 10 for the initial AddRoundKey.
    assign round_sel = busy ? round_cnt : NUM_ROUNDS;
    assign last      = busy & (round_cnt == 4'd0);

    aes_key_expand u_key_expand (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .key      (key),
        .round_sel(round_sel),
        .round_key(round_key),
        .ready    (key_ready)
    );

    aes_inv_round u_inv_round (
        .cur_state (round_state),
        .round_key (round_key),
        .last      (last),
        .next_state(next_state)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DEC_IDLE;
            round_cnt <= '0;
            done      <= 1'b0;
            plaintext <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        state     <= DEC_RUN;
                        round_cnt <= NUM_ROUNDS - 4'd1;
                    end
                end
                DEC_RUN: begin
                    if (last) begin
                        state     <= DEC_IDLE;
                        done      <= 1'b1;
                        plaintext <= next_state;
                    end else begin
                        round_cnt <= round_cnt - 4'd1;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            round_state <= ciphertext ^ round_key;
        end else if (busy) begin
            round_state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: sim/aes_decrypt_props.sv
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt_props
    import aes_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire start,
    input wire key_ready,
    input wire busy,
    input wire done
);

    logic accepted;
    int   fail_count = 0;

    assign accepted = start & key_ready & ~busy;

    // done is sampled high one edge after the edge that sets it.
    assert property (@(posedge clk) disable iff (!rst_n)
        accepted |=> (!done) [*NUM_ROUNDS] ##1 done)
        else begin
            $error("done did not follow an accepted start after ten cycles");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    assert property (@(posedge clk) !rst_n |-> !busy && !done)
        else begin
            $error("busy or done high while in reset");
            fail_count++;
        end

endmodule

bind aes_decrypt aes_decrypt_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .key_ready(key_ready),
    .busy     (busy),
    .done     (done)
);

`default_nettype wire

// File: sim/aes_decrypt_tb.sv
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt_tb
    import aes_pkg::*;
();

    localparam int NUM_CASES      = 7;
    localparam int DONE_TIMEOUT   = 40;
    localparam int READY_TIMEOUT  = 40;
    localparam int NO_DONE_CYCLES = 20;
    localparam int STROBE_NONE    = 0;
    localparam int STROBE_START   = 1;
    localparam int STROBE_KEY     = 2;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   key_load;
    block_t key;
    logic   start;
    block_t ciphertext;
    wire    key_ready;
    wire    busy;
    wire    done;
    block_t plaintext;

    logic [383:0] cases_mem [0:NUM_CASES-1];
    block_t       case_key [NUM_CASES];
    block_t       case_ct [NUM_CASES];
    block_t       case_pt [NUM_CASES];
    int           seed_init;

    always #50 clk = ~clk;

    aes_decrypt DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_load  (key_load),
        .key       (key),
        .start     (start),
        .ciphertext(ciphertext),
        .key_ready (key_ready),
        .busy      (busy),
        .done      (done),
        .plaintext (plaintext)
    );

    task automatic report_failure(string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_equal(string name, logic [127:0] expected, logic [127:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("CHECK FAILED: %s expected %0h actual %0h",
                                     name, expected, actual));
        end
    endtask

    always @(DUT.u_props.fail_count) begin
        assert (DUT.u_props.fail_count == 0) else begin
            report_failure("a property bound to the DUT failed");
        end
    end

    // key is taken on the edge after the pulse is driven.
    task automatic load_key_check(string name, block_t k);
        int n;
        bit rdy;
        n   = 0;
        rdy = 1'b0;
        @(posedge clk);
        key_load <= 1'b1;
        key      <= k;
        @(posedge clk);
        key_load <= 1'b0;
        while (!rdy && n < READY_TIMEOUT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            rdy = key_ready;
        end
        assert (rdy) else begin
            report_failure({"timed out waiting for key_ready in ", name});
        end
        // ten expansion edges follow the accepting edge.
        check_equal({name, " ready latency"}, NUM_ROUNDS, n);
    endtask

    task automatic decrypt_check(string name, block_t ct, block_t exp, int strobe,
                                 block_t strobe_key);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        @(posedge clk);
        start      <= 1'b1;
        ciphertext <= ct;
        @(posedge clk);
        start <= 1'b0;
        while (!seen && n < DONE_TIMEOUT) begin
            @(posedge clk);
            n++;
            // stray strobes land in the middle of the block.
            if (n == 3) begin
                if (strobe == STROBE_START) begin
                    start      <= 1'b1;
                    ciphertext <= ~ct;
                end else if (strobe == STROBE_KEY) begin
                    key_load <= 1'b1;
                    key      <= strobe_key;
                end
            end else if (n == 4) begin
                start    <= 1'b0;
                key_load <= 1'b0;
            end
            @(negedge clk);
            if (n == 1) begin
                check_equal({name, " busy after start"}, 1'b1, busy);
            end
            seen = done;
        end
        assert (seen) else begin
            report_failure({"timed out waiting for done in ", name});
        end
        check_equal({name, " latency"}, NUM_ROUNDS, n);
        check_equal({name, " plaintext"}, exp, plaintext);
        check_equal({name, " busy at done"}, 1'b0, busy);
    endtask

    // random idle gap, plaintext must not move.
    task automatic idle_hold_check(string name, block_t held);
        int gap;
        gap = $urandom % 6;
        repeat (gap) begin
            @(posedge clk);
            @(negedge clk);
            check_equal({name, " plaintext held"}, held, plaintext);
            check_equal({name, " done while idle"}, 1'b0, done);
        end
    endtask

    task automatic no_key_start_check(string name, block_t ct);
        @(posedge clk);
        start      <= 1'b1;
        ciphertext <= ct;
        @(posedge clk);
        start <= 1'b0;
        repeat (NO_DONE_CYCLES) begin
            @(negedge clk);
            check_equal({name, " done"}, 1'b0, done);
            check_equal({name, " busy"}, 1'b0, busy);
            @(posedge clk);
        end
    endtask

    initial begin
        seed_init = $urandom(61898);
        rst_n      <= 1'b0;
        key_load   <= 1'b0;
        key        <= '0;
        start      <= 1'b0;
        ciphertext <= '0;

        $readmemh("sim/aes_cases.txt", cases_mem);
        assert (!$isunknown(cases_mem[NUM_CASES-1])) else begin
            report_failure("the case file sim/aes_cases.txt could not be read completely");
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            case_key[i] = cases_mem[i][383:256];
            case_ct[i]  = cases_mem[i][255:128];
            case_pt[i]  = cases_mem[i][127:0];
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_equal("reset key_ready", 1'b0, key_ready);
        check_equal("reset busy", 1'b0, busy);
        check_equal("reset done", 1'b0, done);
        check_equal("reset plaintext", '0, plaintext);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("after reset key_ready", 1'b0, key_ready);
        check_equal("after reset plaintext", '0, plaintext);

        no_key_start_check("start without key", case_ct[0]);

        load_key_check("first key", case_key[0]);
        for (int i = 0; i < 5; i++) begin
            idle_hold_check($sformatf("gap before case %0d", i),
                            (i == 0) ? block_t'('0) : case_pt[i-1]);
            decrypt_check($sformatf("case %0d", i), case_ct[i], case_pt[i],
                          STROBE_NONE, '0);
        end
        idle_hold_check("gap after case 4", case_pt[4]);

        decrypt_check("start while busy", case_ct[1], case_pt[1], STROBE_START, '0);
        idle_hold_check("gap after start while busy", case_pt[1]);

        decrypt_check("key load while busy", case_ct[3], case_pt[3], STROBE_KEY,
                      case_key[5]);
        @(negedge clk);
        check_equal("key_ready after ignored load", 1'b1, key_ready);
        decrypt_check("old key kept", case_ct[4], case_pt[4], STROBE_NONE, '0);
        idle_hold_check("gap before key change", case_pt[4]);

        load_key_check("second key", case_key[5]);
        check_equal("plaintext over key load", case_pt[4], plaintext);
        for (int i = 5; i < NUM_CASES; i++) begin
            decrypt_check($sformatf("case %0d", i), case_ct[i], case_pt[i],
                          STROBE_NONE, '0);
            idle_hold_check($sformatf("gap after case %0d", i), case_pt[i]);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_inv_sbox.sv
source/aes_key_expand.sv
source/aes_inv_round.sv
source/aes_decrypt.sv
sim/aes_decrypt_props.sv
sim/aes_decrypt_tb.sv

// File: sim/aes_cases.txt
// each line: key, ciphertext, expected plaintext, 32 hex digits each, concatenated
// lines 0 to 4 share one key, lines 5 and 6 use an all-zero key
2b7e151628aed2a6abf7158809cf4f3c3925841d02dc09fbdc118597196a0b323243f6a8885a308d313198a2e0370734
2b7e151628aed2a6abf7158809cf4f3c3ad77bb40d7a3660a89ecaf32466ef976bc1bee22e409f96e93d7e117393172a
2b7e151628aed2a6abf7158809cf4f3cf5d3d58503b9699de785895a96fdbaafae2d8a571e03ac9c9eb76fac45af8e51
2b7e151628aed2a6abf7158809cf4f3c43b1cd7f598ece23881b00e3ed03068830c81c46a35ce411e5fbc1191a0a52ef
2b7e151628aed2a6abf7158809cf4f3c7b0c785e27e8ad3f8223207104725dd4f69f2445df4f9b17ad2b417be66c3710
0000000000000000000000000000000066e94bd4ef8a2c3b884cfa59ca342b2e00000000000000000000000000000000
000000000000000000000000000000000336763e966d92595a567cc9ce537f5ef34481ec3cc627bacd5dc3fb08f273e6
